// File: include/exec_params.svh
// Execute cluster parameters
// Widths, lane count, opcodes and ALU operation codes
`ifndef EXEC_PARAMS_SVH
`define EXEC_PARAMS_SVH

`define DATA_W      16
`define NUM_LANES   4
`define LANE_IDX_W  $clog2(`NUM_LANES)

// Immediate format opcodes
`define OP_ADDI     5'b01000
`define OP_SUBI     5'b01001
`define OP_XORI     5'b01010
`define OP_ANDNI    5'b01011
`define OP_ROLI     5'b10100
`define OP_SLLI     5'b10101
`define OP_RORI     5'b10110
`define OP_SRLI     5'b10111

// Register format opcodes
`define OP_BTR      5'b11001
`define OP_SHIFT_R  5'b11010
`define OP_ALU_R    5'b11011
`define OP_SEQ      5'b11100
`define OP_SLT      5'b11101
`define OP_SLE      5'b11110
`define OP_SCO      5'b11111

// ALU operations, shifts in the lower half
`define ALU_ROL     3'b000
`define ALU_SLL     3'b001
`define ALU_ROR     3'b010
`define ALU_SRL     3'b011
`define ALU_ADD     3'b100
`define ALU_OR      3'b101
`define ALU_XOR     3'b110
`define ALU_AND     3'b111

`endif

// File: hdl/execPkg.sv
// Execute cluster types
// Instruction word seen as either the register or the immediate format
package execPkg;

    // Register format, func picks the operation within an opcode
    typedef struct packed {
        logic [4:0] opcode;
        logic [2:0] rs;
        logic [2:0] rt;
        logic [2:0] rd;
        logic [1:0] func;
    } rFmt_t;

    // Immediate format with a five bit immediate
    typedef struct packed {
        logic [4:0] opcode;
        logic [2:0] rs;
        logic [2:0] rd;
        logic [4:0] imm;
    } iFmt_t;

    typedef union packed {
        rFmt_t rFmt;
        iFmt_t iFmt;
    } instrWord_u;

endpackage

// File: hdl/aluCore.sv
// ALU core
// Add with carry-in, logic ops, shifts and rotates on optionally inverted operands
`timescale 1ns/100ps
`include "exec_params.svh"

module aluCore (
    input  logic [`DATA_W-1:0] a,
    input  logic [`DATA_W-1:0] b,
    input  logic [2:0]         oper,
    input  logic               invA,
    input  logic               invB,
    input  logic               cin,
    output logic [`DATA_W-1:0] result,
    output logic               zero,
    output logic               ltz,
    output logic               ofl,
    output logic               cout
);

    logic [`DATA_W-1:0]   opA;
    logic [`DATA_W-1:0]   opB;
    logic [`DATA_W:0]     sum;
    logic [3:0]           shAmt;
    logic [2*`DATA_W-1:0] rolWide;
    logic [2*`DATA_W-1:0] rorWide;
    logic                 addOfl;

    assign opA   = invA ? ~a : a;
    assign opB   = invB ? ~b : b;
    assign shAmt = b[3:0];

    assign sum = {1'b0, opA} + {1'b0, opB} + {{`DATA_W{1'b0}}, cin};

    // Signed overflow when both operands agree in sign and the sum does not
    assign addOfl = (opA[`DATA_W-1] == opB[`DATA_W-1]) &&
                    (sum[`DATA_W-1] != opA[`DATA_W-1]);

    // Rotates through a doubled copy of the operand
    assign rolWide = {opA, opA} << shAmt;
    assign rorWide = {opA, opA} >> shAmt;

    always_comb begin
        case (oper)
            `ALU_ROL: result = rolWide[2*`DATA_W-1:`DATA_W];
            `ALU_SLL: result = opA << shAmt;
            `ALU_ROR: result = rorWide[`DATA_W-1:0];
            `ALU_SRL: result = opA >> shAmt;
            `ALU_ADD: result = sum[`DATA_W-1:0];
            `ALU_OR:  result = opA | opB;
            `ALU_XOR: result = opA ^ opB;
            default:  result = opA & opB;
        endcase
    end

    assign zero = (result == '0);
    assign ofl  = (oper == `ALU_ADD) && addOfl;
    assign cout = sum[`DATA_W];

    // True sign of the sum, the result sign flips back on overflow
    assign ltz = (oper == `ALU_ADD) ? (sum[`DATA_W-1] ^ addOfl) : result[`DATA_W-1];

endmodule

// File: hdl/executeLane.sv
// Execute lane
// Decodes one instruction, runs it through the ALU and holds the result until released
`timescale 1ns/100ps
`include "exec_params.svh"

module executeLane import execPkg::*; (
    input  logic               clk,
    input  logic               rstN,
    input  logic               start,
    input  instrWord_u         instr,
    input  logic [`DATA_W-1:0] data1,
    input  logic [`DATA_W-1:0] data2,
    input  logic               releaseLane,
    output logic               full,
    output logic [`DATA_W-1:0] result,
    output logic               zero,
    output logic               ltz,
    output logic               err
);

    logic [4:0]         opcode;
    logic [`DATA_W-1:0] sextImm;
    logic [`DATA_W-1:0] zextImm;
    logic [`DATA_W-1:0] shiftImm;
    logic [`DATA_W-1:0] opB;
    logic [`DATA_W-1:0] btrVal;
    logic [2:0]         aluOper;
    logic               aluInvA;
    logic               aluInvB;
    logic               aluCin;
    logic               chkOfl;
    logic               illegal;
    logic [`DATA_W-1:0] aluResult;
    logic               aluZero;
    logic               aluLtz;
    logic               aluOfl;
    logic               aluCout;
    logic [`DATA_W-1:0] finalResult;
    logic               finalErr;

    assign opcode   = instr.rFmt.opcode;
    assign sextImm  = {{(`DATA_W-5){instr.iFmt.imm[4]}}, instr.iFmt.imm};
    assign zextImm  = {{(`DATA_W-5){1'b0}}, instr.iFmt.imm};
    assign shiftImm = {{(`DATA_W-4){1'b0}}, instr.iFmt.imm[3:0]};

    // Operation and operand select
    always_comb begin
        aluOper = `ALU_ADD;
        aluInvA = 1'b0;
        aluInvB = 1'b0;
        aluCin  = 1'b0;
        opB     = data2;
        chkOfl  = 1'b0;
        illegal = 1'b0;
        case (opcode)
            `OP_ADDI: begin
                opB    = sextImm;
                chkOfl = 1'b1;
            end
            // B - A as ~A + B + 1
            `OP_SUBI: begin
                opB     = sextImm;
                aluInvA = 1'b1;
                aluCin  = 1'b1;
                chkOfl  = 1'b1;
            end
            `OP_XORI: begin
                opB     = zextImm;
                aluOper = `ALU_XOR;
            end
            `OP_ANDNI: begin
                opB     = zextImm;
                aluOper = `ALU_AND;
                aluInvB = 1'b1;
            end
            `OP_ROLI, `OP_SLLI, `OP_RORI, `OP_SRLI: begin
                opB     = shiftImm;
                aluOper = {1'b0, opcode[1:0]};
            end
            `OP_SHIFT_R: aluOper = {1'b0, instr.rFmt.func};
            `OP_ALU_R: begin
                case (instr.rFmt.func)
                    2'b00: chkOfl = 1'b1;
                    2'b01: begin
                        aluInvA = 1'b1;
                        aluCin  = 1'b1;
                        chkOfl  = 1'b1;
                    end
                    2'b10: aluOper = `ALU_XOR;
                    default: begin
                        aluOper = `ALU_AND;
                        aluInvB = 1'b1;
                    end
                endcase
            end
            // Compares run A - B and read the flags
            `OP_SEQ, `OP_SLT, `OP_SLE: begin
                aluInvB = 1'b1;
                aluCin  = 1'b1;
            end
            `OP_SCO, `OP_BTR: ;
            default: illegal = 1'b1;
        endcase
    end

    aluCore u_aluCore (
        .a      (data1),
        .b      (opB),
        .oper   (aluOper),
        .invA   (aluInvA),
        .invB   (aluInvB),
        .cin    (aluCin),
        .result (aluResult),
        .zero   (aluZero),
        .ltz    (aluLtz),
        .ofl    (aluOfl),
        .cout   (aluCout)
    );

    always_comb begin
        for (int i = 0; i < `DATA_W; i++) begin
            btrVal[i] = data1[`DATA_W-1-i];
        end
    end

    // Final result, set instructions give a single bit
    always_comb begin
        case (opcode)
            `OP_BTR: finalResult = btrVal;
            `OP_SEQ: finalResult = {{(`DATA_W-1){1'b0}}, aluZero};
            `OP_SLT: finalResult = {{(`DATA_W-1){1'b0}}, aluLtz};
            `OP_SLE: finalResult = {{(`DATA_W-1){1'b0}}, aluZero | aluLtz};
            `OP_SCO: finalResult = {{(`DATA_W-1){1'b0}}, aluCout};
            default: finalResult = illegal ? '0 : aluResult;
        endcase
    end

    assign finalErr = illegal | (chkOfl & aluOfl);

    always_ff @(posedge clk) begin
        if (!rstN) begin
            full <= 1'b0;
        end else if (start) begin
            full <= 1'b1;
        end else if (releaseLane) begin
            full <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (start) begin
            result <= finalResult;
            zero   <= (finalResult == '0);
            ltz    <= finalResult[`DATA_W-1];
            err    <= finalErr;
        end
    end

    // The issue unit only targets a free lane
    startWhileFull: assert property (@(posedge clk) disable iff (!rstN) start |-> !full);

endmodule

// File: hdl/issueUnit.sv
// Issue unit
// Accepts instructions over the input four-phase handshake, round-robin over the lanes
`timescale 1ns/100ps
`include "exec_params.svh"

module issueUnit import execPkg::*; (
    input  logic                   clk,
    input  logic                   rstN,
    input  logic                   inReq,
    input  instrWord_u             inInstr,
    input  logic [`DATA_W-1:0]     inData1,
    input  logic [`DATA_W-1:0]     inData2,
    input  logic [`NUM_LANES-1:0]  laneFull,
    output logic                   inAck,
    output logic [`NUM_LANES-1:0]  laneStart,
    output instrWord_u             laneInstr,
    output logic [`DATA_W-1:0]     laneData1,
    output logic [`DATA_W-1:0]     laneData2
);

    logic [`LANE_IDX_W-1:0] wrPtr;
    logic                   accept;

    // Take a new request only with ack low and a free target lane
    assign accept = inReq && !inAck && !laneFull[wrPtr];

    always_ff @(posedge clk) begin
        if (!rstN) begin
            inAck     <= 1'b0;
            laneStart <= '0;
            wrPtr     <= '0;
        end else begin
            laneStart <= '0;
            if (accept) begin
                inAck            <= 1'b1;
                laneStart[wrPtr] <= 1'b1;
                wrPtr <= (wrPtr == `LANE_IDX_W'(`NUM_LANES-1)) ? '0 : wrPtr + 1'b1;
            end else if (inAck && !inReq) begin
                inAck <= 1'b0;
            end
        end
    end

    // Operands travel with the start pulse
    always_ff @(posedge clk) begin
        if (accept) begin
            laneInstr <= inInstr;
            laneData1 <= inData1;
            laneData2 <= inData2;
        end
    end

    ackNeedsReq: assert property (@(posedge clk) disable iff (!rstN)
        $rose(inAck) |-> $past(inReq));
    startOneHot: assert property (@(posedge clk) disable iff (!rstN) $onehot0(laneStart));

endmodule

// File: hdl/resultCollector.sv
// Result collector
// Drains full lanes in issue order onto the output four-phase handshake
`timescale 1ns/100ps
`include "exec_params.svh"

module resultCollector (
    input  logic                              clk,
    input  logic                              rstN,
    input  logic [`NUM_LANES-1:0]             laneFull,
    input  logic [`NUM_LANES-1:0][`DATA_W-1:0] laneResult,
    input  logic [`NUM_LANES-1:0]             laneZero,
    input  logic [`NUM_LANES-1:0]             laneLtz,
    input  logic [`NUM_LANES-1:0]             laneErr,
    input  logic                              outAck,
    output logic [`NUM_LANES-1:0]             laneRelease,
    output logic                              outReq,
    output logic [`DATA_W-1:0]                outResult,
    output logic                              outZero,
    output logic                              outLtz,
    output logic                              outErr
);

    logic [`LANE_IDX_W-1:0] rdPtr;
    logic                   launch;

    // Next result goes out once the sink has dropped its ack
    assign launch = !outReq && !outAck && laneFull[rdPtr];

    always_ff @(posedge clk) begin
        if (!rstN) begin
            outReq      <= 1'b0;
            laneRelease <= '0;
            rdPtr       <= '0;
        end else begin
            laneRelease <= '0;
            if (launch) begin
                outReq <= 1'b1;
            end else if (outReq && outAck) begin
                outReq             <= 1'b0;
                laneRelease[rdPtr] <= 1'b1;
                rdPtr <= (rdPtr == `LANE_IDX_W'(`NUM_LANES-1)) ? '0 : rdPtr + 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (launch) begin
            outResult <= laneResult[rdPtr];
            outZero   <= laneZero[rdPtr];
            outLtz    <= laneLtz[rdPtr];
            outErr    <= laneErr[rdPtr];
        end
    end

    outDataStable: assert property (@(posedge clk) disable iff (!rstN)
        outReq |=> (!outReq || $stable({outResult, outZero, outLtz, outErr})));

endmodule

// File: hdl/executeCluster.sv
// Execute cluster top
// Issue unit feeding a set of execute lanes, drained in order by the collector
`timescale 1ns/100ps
`include "exec_params.svh"

module executeCluster import execPkg::*; (
    input  logic               clk,
    input  logic               rstN,
    input  logic               inReq,
    input  instrWord_u         inInstr,
    input  logic [`DATA_W-1:0] inData1,
    input  logic [`DATA_W-1:0] inData2,
    output logic               inAck,
    output logic               outReq,
    output logic [`DATA_W-1:0] outResult,
    output logic               outZero,
    output logic               outLtz,
    output logic               outErr,
    input  logic               outAck
);

    logic [`NUM_LANES-1:0]              laneStart;
    logic [`NUM_LANES-1:0]              laneFull;
    logic [`NUM_LANES-1:0]              laneRelease;
    logic [`NUM_LANES-1:0][`DATA_W-1:0] laneResult;
    logic [`NUM_LANES-1:0]              laneZero;
    logic [`NUM_LANES-1:0]              laneLtz;
    logic [`NUM_LANES-1:0]              laneErr;
    instrWord_u                         laneInstr;
    logic [`DATA_W-1:0]                 laneData1;
    logic [`DATA_W-1:0]                 laneData2;

    issueUnit u_issueUnit (
        .clk, .rstN, .inReq, .inInstr, .inData1, .inData2, .laneFull,
        .inAck, .laneStart, .laneInstr, .laneData1, .laneData2
    );

    for (genvar i = 0; i < `NUM_LANES; i++) begin : gLane
        executeLane u_executeLane (
            .clk         (clk),
            .rstN        (rstN),
            .start       (laneStart[i]),
            .instr       (laneInstr),
            .data1       (laneData1),
            .data2       (laneData2),
            .releaseLane (laneRelease[i]),
            .full        (laneFull[i]),
            .result      (laneResult[i]),
            .zero        (laneZero[i]),
            .ltz         (laneLtz[i]),
            .err         (laneErr[i])
        );
    end

    resultCollector u_resultCollector (
        .clk, .rstN, .laneFull, .laneResult, .laneZero, .laneLtz, .laneErr, .outAck,
        .laneRelease, .outReq, .outResult, .outZero, .outLtz, .outErr
    );

endmodule

// File: testbench/tbClockGen.sv
// Testbench clock and reset source
// 100 ns clock, active low reset held for the first 5 cycles
`timescale 1ns/100ps

module tbClockGen (
    output logic clk,
    output logic rstN
);

    localparam int HALF_PERIOD = 50;
    localparam int RESET_CYCLES = 5;

    initial begin
        clk = 1'b0;
        forever #HALF_PERIOD clk = ~clk;
    end

    // Released just after an edge, like the other testbench inputs
    initial begin
        rstN = 1'b0;
        repeat (RESET_CYCLES) @(posedge clk);
        #1 rstN = 1'b1;
    end

endmodule

// File: testbench/executeClusterTb.sv
// Execute cluster testbench
// Feeds a table of instructions through the input handshake and checks results in order
`timescale 1ns/100ps
`include "exec_params.svh"

module executeClusterTb import execPkg::*; ();

    localparam int CLK_PERIOD = 100;
    localparam int CYCLES_PER_ENTRY = 40;

    logic               clk;
    logic               rstN;
    logic               inReq;
    instrWord_u         inInstr;
    logic [`DATA_W-1:0] inData1;
    logic [`DATA_W-1:0] inData2;
    logic               inAck;
    logic               outReq;
    logic [`DATA_W-1:0] outResult;
    logic               outZero;
    logic               outLtz;
    logic               outErr;
    logic               outAck;

    // Stimulus and expected values with one entry per instruction
    logic [15:0] vecInstr[$];
    logic [15:0] vecRs[$];
    logic [15:0] vecRt[$];
    logic [15:0] vecResult[$];
    bit          vecZero[$];
    bit          vecLtz[$];
    bit          vecErr[$];

    bit          tableReady;
    int          errorCount;
    int          checkCount;
    int          acceptCount;
    int          doneCount;
    int          maxInFlight;
    logic        prevAck;
    logic        prevOutReq;
    logic [31:0] lcgState;

    tbClockGen u_tbClockGen (.clk(clk), .rstN(rstN));

    executeCluster u_executeCluster (
        .clk, .rstN, .inReq, .inInstr, .inData1, .inData2, .inAck,
        .outReq, .outResult, .outZero, .outLtz, .outErr, .outAck
    );

    // Register fields hold arbitrary numbers that the lanes ignore
    function automatic logic [15:0] packR(input logic [4:0] op, input logic [1:0] func);
        return {op, 3'd1, 3'd2, 3'd3, func};
    endfunction

    function automatic logic [15:0] packI(input logic [4:0] op, input logic [4:0] imm);
        return {op, 3'd1, 3'd4, imm};
    endfunction

    function automatic logic [31:0] nextRandom();
        lcgState = lcgState * 32'd1103515245 + 32'd12345;
        return lcgState;
    endfunction

    task automatic addVector(input logic [15:0] instr, input logic [15:0] rs,
                             input logic [15:0] rt, input logic [15:0] res,
                             input bit z, input bit l, input bit e);
        vecInstr.push_back(instr);
        vecRs.push_back(rs);
        vecRt.push_back(rt);
        vecResult.push_back(res);
        vecZero.push_back(z);
        vecLtz.push_back(l);
        vecErr.push_back(e);
    endtask

    task automatic loadTable();
        addVector(packR(`OP_ALU_R, 2'b00), 16'h1234, 16'h4321, 16'h5555, 0, 0, 0);
        addVector(packR(`OP_ALU_R, 2'b00), 16'h7000, 16'h1000, 16'h8000, 0, 1, 1);
        // sub gives Rt - Rs
        addVector(packR(`OP_ALU_R, 2'b01), 16'h0005, 16'h0003, 16'hFFFE, 0, 1, 0);
        addVector(packR(`OP_ALU_R, 2'b01), 16'h0001, 16'h8000, 16'h7FFF, 0, 0, 1);
        addVector(packI(`OP_ADDI, 5'h1D),  16'h0010, 16'hDEAD, 16'h000D, 0, 0, 0);
        addVector(packI(`OP_SUBI, 5'h07),  16'h0010, 16'hDEAD, 16'hFFF7, 0, 1, 0);
        addVector(packI(`OP_SUBI, 5'h05),  16'h0005, 16'h0000, 16'h0000, 1, 0, 0);
        addVector(packR(`OP_ALU_R, 2'b10), 16'hF0F0, 16'hFF00, 16'h0FF0, 0, 0, 0);
        addVector(packR(`OP_ALU_R, 2'b11), 16'hABCD, 16'h00FF, 16'hAB00, 0, 1, 0);
        addVector(packI(`OP_XORI, 5'h1F),  16'h1234, 16'h0000, 16'h122B, 0, 0, 0);
        addVector(packI(`OP_ANDNI, 5'h10), 16'hFFFF, 16'h0000, 16'hFFEF, 0, 1, 0);
        // Register shifts use only the low four bits of Rt
        addVector(packR(`OP_SHIFT_R, 2'b01), 16'h0001, 16'h000F, 16'h8000, 0, 1, 0);
        addVector(packR(`OP_SHIFT_R, 2'b11), 16'h8000, 16'h0014, 16'h0800, 0, 0, 0);
        addVector(packR(`OP_SHIFT_R, 2'b00), 16'h8001, 16'h0001, 16'h0003, 0, 0, 0);
        addVector(packR(`OP_SHIFT_R, 2'b10), 16'h0001, 16'h0004, 16'h1000, 0, 0, 0);
        addVector(packI(`OP_ROLI, 5'h04),  16'h1234, 16'h0000, 16'h2341, 0, 0, 0);
        addVector(packI(`OP_SLLI, 5'h13),  16'h00FF, 16'h0000, 16'h07F8, 0, 0, 0);
        addVector(packI(`OP_RORI, 5'h08),  16'h1234, 16'h0000, 16'h3412, 0, 0, 0);
        addVector(packI(`OP_SRLI, 5'h0F),  16'hFFFF, 16'h0000, 16'h0001, 0, 0, 0);
        addVector(packR(`OP_SEQ, 2'b00),   16'h5A5A, 16'h5A5A, 16'h0001, 0, 0, 0);
        addVector(packR(`OP_SEQ, 2'b00),   16'h5A5A, 16'h5A5B, 16'h0000, 1, 0, 0);
        // Signed compares where A - B overflows
        addVector(packR(`OP_SLT, 2'b00),   16'h8000, 16'h0001, 16'h0001, 0, 0, 0);
        addVector(packR(`OP_SLT, 2'b00),   16'h0001, 16'h8000, 16'h0000, 1, 0, 0);
        addVector(packR(`OP_SLE, 2'b00),   16'h8000, 16'h0001, 16'h0001, 0, 0, 0);
        addVector(packR(`OP_SLE, 2'b00),   16'h7FFF, 16'h8000, 16'h0000, 1, 0, 0);
        addVector(packR(`OP_SLE, 2'b00),   16'hFFFF, 16'hFFFF, 16'h0001, 0, 0, 0);
        addVector(packR(`OP_SCO, 2'b00),   16'hFFFF, 16'h0001, 16'h0001, 0, 0, 0);
        addVector(packR(`OP_SCO, 2'b00),   16'h1000, 16'h2000, 16'h0000, 1, 0, 0);
        addVector(packR(`OP_BTR, 2'b00),   16'h1234, 16'h0000, 16'h2C48, 0, 0, 0);
        // Opcode 00000 is not implemented
        addVector(packR(5'b00000, 2'b00),  16'h1111, 16'h2222, 16'h0000, 1, 0, 1);
    endtask

    task automatic checkValue(input string name, input logic [15:0] got,
                              input logic [15:0] expected);
        checkCount++;
        if (got !== expected) begin
            errorCount++;
            $display("error %s: got 0x%h, expected 0x%h", name, got, expected);
        end
    endtask

    task automatic stepCycle();
        @(posedge clk);
        #1;
    endtask

    task automatic driveInputs();
        for (int i = 0; i < vecInstr.size(); i++) begin
            inReq   = 1'b1;
            inInstr = vecInstr[i];
            inData1 = vecRs[i];
            inData2 = vecRt[i];
            do stepCycle(); while (!inAck);
            inReq = 1'b0;
            do stepCycle(); while (inAck);
        end
    endtask

    task automatic collectOutputs();
        int unsigned delay;
        for (int i = 0; i < vecInstr.size(); i++) begin
            while (!outReq) stepCycle();
            checkValue($sformatf("outResult[%0d]", i), outResult, vecResult[i]);
            checkValue($sformatf("outZero[%0d]", i), 16'(outZero), 16'(vecZero[i]));
            checkValue($sformatf("outLtz[%0d]", i), 16'(outLtz), 16'(vecLtz[i]));
            checkValue($sformatf("outErr[%0d]", i), 16'(outErr), 16'(vecErr[i]));
            delay = (nextRandom() >> 16) % 8;
            repeat (delay) stepCycle();
            outAck = 1'b1;
            while (outReq) stepCycle();
            outAck = 1'b0;
        end
    endtask

    // Items in flight counted from inAck rising to outReq falling
    always @(negedge clk) begin
        if (rstN) begin
            if (inAck && !prevAck) acceptCount++;
            if (!outReq && prevOutReq) doneCount++;
            if (acceptCount - doneCount > maxInFlight) maxInFlight = acceptCount - doneCount;
        end
        prevAck = inAck;
        prevOutReq = outReq;
    end

    initial begin
        inReq       = 1'b0;
        inInstr     = '0;
        inData1     = '0;
        inData2     = '0;
        outAck      = 1'b0;
        errorCount  = 0;
        checkCount  = 0;
        acceptCount = 0;
        doneCount   = 0;
        maxInFlight = 0;
        prevAck     = 1'b0;
        prevOutReq  = 1'b0;
        lcgState    = 32'd72;
        loadTable();
        tableReady = 1'b1;

        // Handshake outputs low through reset and just after it
        @(posedge clk);
        while (!rstN) begin
            @(negedge clk);
            checkValue("inAck", 16'(inAck), 16'h0);
            checkValue("outReq", 16'(outReq), 16'h0);
        end
        stepCycle();
        checkValue("inAck", 16'(inAck), 16'h0);
        checkValue("outReq", 16'(outReq), 16'h0);

        fork
            driveInputs();
            collectOutputs();
        join

        repeat (5) stepCycle();
        if (outReq) begin
            errorCount++;
            $display("An extra result appeared after the last table entry");
        end
        if (maxInFlight < 2) begin
            errorCount++;
            $display("No more than one instruction was ever in flight");
        end
        $display("checks %0d, errors %0d, results %0d of %0d, max in flight %0d",
                 checkCount, errorCount, doneCount, vecInstr.size(), maxInFlight);
        if (errorCount == 0) begin
            $display("** PASS **");
        end else begin
            $display("** FAIL **");
        end
        $finish;
    end

    // Watchdog scaled to the table length
    initial begin
        wait (tableReady);
        #(vecInstr.size() * CYCLES_PER_ENTRY * CLK_PERIOD);
        $display("Run timed out with %0d of %0d results received", doneCount, vecInstr.size());
        $display("** FAIL **");
        $finish;
    end

endmodule

// File: execCluster.f
+incdir+include
hdl/execPkg.sv
hdl/aluCore.sv
hdl/executeLane.sv
hdl/issueUnit.sv
hdl/resultCollector.sv
hdl/executeCluster.sv
testbench/tbClockGen.sv
testbench/executeClusterTb.sv

// File: Makefile
VERILATOR = verilator
FLAGS     = --binary --timing
TOP       = executeClusterTb
FILELIST  = execCluster.f

BIN     = obj_dir/V$(TOP)
LOG     = sim.log
SOURCES = $(filter %.sv %.v,$(shell cat $(FILELIST))) include/exec_params.svh

.PHONY: all run clean

all: run

$(BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST)

run: $(BIN)
	./$(BIN) > $(LOG) 2>&1; cat $(LOG)
	@grep -qF '** PASS **' $(LOG) && ! grep -qF '** FAIL **' $(LOG)

clean:
	rm -rf obj_dir $(LOG)
